// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wall -Wno-fatal
TOP       := tb_subsys_main
FILELIST  := build.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: build.f
hw/subsys_pkg.sv
hw/icb_if.sv
hw/icb_periph_fabric.sv
hw/gpio_ctrl.sv
hw/adder_accel.sv
hw/subsys_main.sv
test/tb_subsys_main.sv

// File: hw/adder_accel.sv
// Adder accelerator: 0x0 op_a, 0x4 op_b, 0x8 sum (RO, mod 2^32)
// sum follows the operands one cycle after a write

module adder_accel (
  input logic  clk,
  input logic  rst,
  icb_if.slave bus
);

  localparam int RB = subsys_pkg::REGION_BITS;

  subsys_pkg::xlen_t op_a_q;
  subsys_pkg::xlen_t op_b_q;
  subsys_pkg::xlen_t sum_q;
  subsys_pkg::xlen_t rd_val;
  subsys_pkg::xlen_t rsp_rdata_q;
  logic [RB-1:0]     ofs;
  logic              rsp_valid_q;
  logic              cmd_hs;

  assign ofs    = bus.cmd_addr[RB-1:0];
  assign cmd_hs = bus.cmd_valid & bus.cmd_ready;

  always_comb begin
    case (ofs)
      subsys_pkg::OFS_0: rd_val = op_a_q;
      subsys_pkg::OFS_4: rd_val = op_b_q;
      subsys_pkg::OFS_8: rd_val = sum_q;
      default:           rd_val = '0;
    endcase
  end

  ////////////////////
  // Operands and sum
  always_ff @(posedge clk) begin
    if (rst) begin
      op_a_q <= '0;
      op_b_q <= '0;
      sum_q  <= '0;
    end else begin
      sum_q <= op_a_q + op_b_q;
      if (cmd_hs && !bus.cmd_read) begin
        case (ofs)
          subsys_pkg::OFS_0: op_a_q <= subsys_pkg::apply_wmask(op_a_q, bus.cmd_wdata, bus.cmd_wmask);
          subsys_pkg::OFS_4: op_b_q <= subsys_pkg::apply_wmask(op_b_q, bus.cmd_wdata, bus.cmd_wmask);
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // Response
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hs) begin
      rsp_rdata_q <= bus.cmd_read ? rd_val : '0;
    end
  end

  assign bus.cmd_ready = ~rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_err   = 1'b0;
  assign bus.rsp_rdata = rsp_rdata_q;

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    bus.rsp_valid && !bus.rsp_ready |=> bus.rsp_valid && $stable(bus.rsp_rdata));

endmodule

// File: hw/gpio_ctrl.sv
// GPIO port A: 0x0 input (RO), 0x4 output value, 0x8 output enable
// gpio_in must already be synchronous to clk
// Inspect mode overrides the pads only, registers keep their values

module gpio_ctrl (
  input  logic              clk,
  input  logic              rst,
  icb_if.slave              bus,
  input  subsys_pkg::gpio_t gpio_in,
  input  logic              inspect_mode,
  input  subsys_pkg::addr_t insp_addr,
  input  logic              insp_cmd_valid,
  input  logic              insp_cmd_ready,
  input  logic              insp_rsp_valid,
  input  logic              insp_rsp_ready,
  output subsys_pkg::gpio_t pad_oval,
  output subsys_pkg::gpio_t pad_oe
);

  localparam int RB = subsys_pkg::REGION_BITS;
  localparam int IA = subsys_pkg::INSPECT_ADDR_BITS;

  subsys_pkg::gpio_t oval_q;
  subsys_pkg::gpio_t oe_q;
  subsys_pkg::gpio_t insp_val;
  subsys_pkg::xlen_t rd_val;
  subsys_pkg::xlen_t rsp_rdata_q;
  logic [RB-1:0]     ofs;
  logic              rsp_valid_q;
  logic              cmd_hs;

  assign ofs    = bus.cmd_addr[RB-1:0];
  assign cmd_hs = bus.cmd_valid & bus.cmd_ready;

  ////////////////////
  // Register file
  always_comb begin
    case (ofs)
      subsys_pkg::OFS_0: rd_val = gpio_in;
      subsys_pkg::OFS_4: rd_val = oval_q;
      subsys_pkg::OFS_8: rd_val = oe_q;
      default:           rd_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      oval_q <= '0;
      oe_q   <= '0;
    end else if (cmd_hs && !bus.cmd_read) begin
      case (ofs)
        subsys_pkg::OFS_4: oval_q <= subsys_pkg::apply_wmask(oval_q, bus.cmd_wdata, bus.cmd_wmask);
        subsys_pkg::OFS_8: oe_q   <= subsys_pkg::apply_wmask(oe_q, bus.cmd_wdata, bus.cmd_wmask);
        default: ;
      endcase
    end
  end

  ////////////////////
  // Response
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else if (cmd_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hs) begin
      rsp_rdata_q <= bus.cmd_read ? rd_val : '0;
    end
  end

  assign bus.cmd_ready = ~rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_err   = 1'b0;
  assign bus.rsp_rdata = rsp_rdata_q;

  // Pad takeover: addr low bits, then the four handshake levels
  assign insp_val = {{($bits(subsys_pkg::gpio_t) - IA - 4){1'b0}},
                     insp_rsp_ready, insp_rsp_valid, insp_cmd_ready, insp_cmd_valid,
                     insp_addr[IA-1:0]};

  assign pad_oe   = inspect_mode ? '1 : oe_q;
  assign pad_oval = inspect_mode ? insp_val : oval_q;

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    bus.rsp_valid && !bus.rsp_ready |=> bus.rsp_valid && $stable(bus.rsp_rdata));

endmodule

// File: hw/icb_if.sv
// ICB command and response channels, one transaction per handshake
// Response fields must hold while rsp_valid is high and rsp_ready low

interface icb_if;

  // Command channel
  logic                 cmd_valid;
  logic                 cmd_ready;
  subsys_pkg::addr_t    cmd_addr;
  logic                 cmd_read;
  subsys_pkg::xlen_t    cmd_wdata;
  subsys_pkg::wmask_t   cmd_wmask;

  // Response channel
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic                 rsp_err;
  subsys_pkg::xlen_t    rsp_rdata;

  modport master (
    output cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, rsp_ready,
    input  cmd_ready, rsp_valid, rsp_err, rsp_rdata
  );

  modport slave (
    input  cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, rsp_ready,
    output cmd_ready, rsp_valid, rsp_err, rsp_rdata
  );

endinterface

// File: hw/icb_periph_fabric.sv
// One-outstanding peripheral fabric; decode on addr bits above REGION_BITS
// Unmapped addresses get err=1, rdata=0 from the fabric one cycle later
// Routing is combinational, no extra cycle in either direction

module icb_periph_fabric #(
  parameter subsys_pkg::addr_t GPIO_BASE  = subsys_pkg::GPIO_BASE,
  parameter subsys_pkg::addr_t ADDER_BASE = subsys_pkg::ADDER_BASE
) (
  input logic  clk,
  input logic  rst,
  icb_if.slave  host,
  icb_if.master gpio,
  icb_if.master adder
);

  localparam int AW = $bits(subsys_pkg::addr_t);
  localparam int RB = subsys_pkg::REGION_BITS;

  subsys_pkg::sel_t cmd_sel;
  subsys_pkg::sel_t sel_q;
  logic             pend_q;
  logic             sel_ready;
  logic             cmd_hs;
  logic             rsp_hs;

  ////////////////////
  // Command decode
  always_comb begin
    if (host.cmd_addr[AW-1:RB] == GPIO_BASE[AW-1:RB]) begin
      cmd_sel = subsys_pkg::SEL_GPIO;
    end else if (host.cmd_addr[AW-1:RB] == ADDER_BASE[AW-1:RB]) begin
      cmd_sel = subsys_pkg::SEL_ADDER;
    end else begin
      cmd_sel = subsys_pkg::SEL_ERR;
    end
  end

  always_comb begin
    case (cmd_sel)
      subsys_pkg::SEL_GPIO:  sel_ready = gpio.cmd_ready;
      subsys_pkg::SEL_ADDER: sel_ready = adder.cmd_ready;
      default:               sel_ready = 1'b1;
    endcase
  end

  assign host.cmd_ready = ~pend_q & sel_ready;
  assign cmd_hs = host.cmd_valid & host.cmd_ready;
  assign rsp_hs = host.rsp_valid & host.rsp_ready;

  // Payload fans out, valid only to the selected slave
  assign gpio.cmd_valid  = host.cmd_valid & ~pend_q & (cmd_sel == subsys_pkg::SEL_GPIO);
  assign gpio.cmd_addr   = host.cmd_addr;
  assign gpio.cmd_read   = host.cmd_read;
  assign gpio.cmd_wdata  = host.cmd_wdata;
  assign gpio.cmd_wmask  = host.cmd_wmask;

  assign adder.cmd_valid = host.cmd_valid & ~pend_q & (cmd_sel == subsys_pkg::SEL_ADDER);
  assign adder.cmd_addr  = host.cmd_addr;
  assign adder.cmd_read  = host.cmd_read;
  assign adder.cmd_wdata = host.cmd_wdata;
  assign adder.cmd_wmask = host.cmd_wmask;

  ////////////////////
  // Outstanding transaction
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
      sel_q  <= subsys_pkg::SEL_GPIO;
    end else if (cmd_hs) begin
      pend_q <= 1'b1;
      sel_q  <= cmd_sel;
    end else if (rsp_hs) begin
      pend_q <= 1'b0;
    end
  end

  ////////////////////
  // Response return
  always_comb begin
    host.rsp_valid = 1'b0;
    host.rsp_err   = 1'b0;
    host.rsp_rdata = '0;
    if (pend_q) begin
      case (sel_q)
        subsys_pkg::SEL_GPIO: begin
          host.rsp_valid = gpio.rsp_valid;
          host.rsp_err   = gpio.rsp_err;
          host.rsp_rdata = gpio.rsp_rdata;
        end
        subsys_pkg::SEL_ADDER: begin
          host.rsp_valid = adder.rsp_valid;
          host.rsp_err   = adder.rsp_err;
          host.rsp_rdata = adder.rsp_rdata;
        end
        default: begin
          host.rsp_valid = 1'b1;
          host.rsp_err   = 1'b1;
        end
      endcase
    end
  end

  assign gpio.rsp_ready  = host.rsp_ready & pend_q & (sel_q == subsys_pkg::SEL_GPIO);
  assign adder.rsp_ready = host.rsp_ready & pend_q & (sel_q == subsys_pkg::SEL_ADDER);

  // No slave may still hold a response when a new command is taken
  a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
    cmd_hs |-> !gpio.rsp_valid && !adder.rsp_valid);

  // Taken command is answered next cycle
  a_rsp_next: assert property (@(posedge clk) disable iff (rst)
    cmd_hs |=> host.rsp_valid);

  a_host_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    host.rsp_valid && !host.rsp_ready |=>
      host.rsp_valid && $stable(host.rsp_err) && $stable(host.rsp_rdata));

endmodule

// File: hw/subsys_main.sv
// Peripheral subsystem top: one ICB host port, GPIO port A and the adder
// Single clock, synchronous active-high reset; inspect bits 26-31 read 0

module subsys_main #(
  parameter subsys_pkg::addr_t GPIO_BASE  = subsys_pkg::GPIO_BASE,
  parameter subsys_pkg::addr_t ADDER_BASE = subsys_pkg::ADDER_BASE
) (
  input  logic               clk,
  input  logic               rst,

  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  subsys_pkg::addr_t  cmd_addr,
  input  logic               cmd_read,
  input  subsys_pkg::xlen_t  cmd_wdata,
  input  subsys_pkg::wmask_t cmd_wmask,

  output logic               rsp_valid,
  input  logic               rsp_ready,
  output logic               rsp_err,
  output subsys_pkg::xlen_t  rsp_rdata,

  input  subsys_pkg::gpio_t  gpio_in,
  output subsys_pkg::gpio_t  gpio_oval,
  output subsys_pkg::gpio_t  gpio_oe,

  input  logic               inspect_mode
);

  icb_if host_bus ();
  icb_if gpio_bus ();
  icb_if adder_bus ();

  ////////////////////
  // Host port onto the internal bus
  assign host_bus.cmd_valid = cmd_valid;
  assign host_bus.cmd_addr  = cmd_addr;
  assign host_bus.cmd_read  = cmd_read;
  assign host_bus.cmd_wdata = cmd_wdata;
  assign host_bus.cmd_wmask = cmd_wmask;
  assign host_bus.rsp_ready = rsp_ready;

  assign cmd_ready = host_bus.cmd_ready;
  assign rsp_valid = host_bus.rsp_valid;
  assign rsp_err   = host_bus.rsp_err;
  assign rsp_rdata = host_bus.rsp_rdata;

  icb_periph_fabric #(
    .GPIO_BASE  (GPIO_BASE),
    .ADDER_BASE (ADDER_BASE)
  ) u_fabric (
    .clk   (clk),
    .rst   (rst),
    .host  (host_bus.slave),
    .gpio  (gpio_bus.master),
    .adder (adder_bus.master)
  );

  // Host handshake levels go to the pads in inspect mode
  gpio_ctrl u_gpio (
    .clk            (clk),
    .rst            (rst),
    .bus            (gpio_bus.slave),
    .gpio_in        (gpio_in),
    .inspect_mode   (inspect_mode),
    .insp_addr      (cmd_addr),
    .insp_cmd_valid (cmd_valid),
    .insp_cmd_ready (host_bus.cmd_ready),
    .insp_rsp_valid (host_bus.rsp_valid),
    .insp_rsp_ready (rsp_ready),
    .pad_oval       (gpio_oval),
    .pad_oe         (gpio_oe)
  );

  adder_accel u_adder (
    .clk (clk),
    .rst (rst),
    .bus (adder_bus.slave)
  );

endmodule

// File: hw/subsys_pkg.sv
// Shared bus types, address map and register offsets for the peripheral subsystem
// Regions are decoded on the address bits above REGION_BITS only

package subsys_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  wmask_t;
  typedef logic [31:0] gpio_t;

  ////////////////////
  // Address map
  localparam addr_t GPIO_BASE  = 32'h1001_2000;
  localparam addr_t ADDER_BASE = 32'h1004_1000;
  localparam int    REGION_BITS = 12;

  localparam logic [REGION_BITS-1:0] OFS_0 = 12'h000;
  localparam logic [REGION_BITS-1:0] OFS_4 = 12'h004;
  localparam logic [REGION_BITS-1:0] OFS_8 = 12'h008;

  // Low address bits driven onto the pads in inspect mode
  localparam int INSPECT_ADDR_BITS = 22;

  typedef enum logic [1:0] {
    SEL_GPIO,
    SEL_ADDER,
    SEL_ERR
  } sel_t;

  // Byte-lane merge for register writes
  function automatic xlen_t apply_wmask(xlen_t cur, xlen_t wdata, wmask_t wmask);
    xlen_t res;
    res = cur;
    for (int i = 0; i < $bits(wmask_t); i++) begin
      if (wmask[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: test/tb_subsys_main.sv
// Testbench for subsys_main: GPIO and decode table, random adder operands, inspect pads
// Each response is held back 0 to 3 cycles at random; every wait is bounded

module tb_subsys_main;

  localparam int TIMEOUT = 20;
  localparam int NROWS   = 13;

  localparam subsys_pkg::addr_t GPIO_IN_ADDR = subsys_pkg::GPIO_BASE;
  localparam subsys_pkg::addr_t OVAL_ADDR    = subsys_pkg::GPIO_BASE + 32'h4;
  localparam subsys_pkg::addr_t OE_ADDR      = subsys_pkg::GPIO_BASE + 32'h8;
  localparam subsys_pkg::addr_t OP_A_ADDR    = subsys_pkg::ADDER_BASE;
  localparam subsys_pkg::addr_t OP_B_ADDR    = subsys_pkg::ADDER_BASE + 32'h4;
  localparam subsys_pkg::addr_t SUM_ADDR     = subsys_pkg::ADDER_BASE + 32'h8;

  // GPIO register contents once the table has run
  localparam subsys_pkg::xlen_t OVAL_FINAL = 32'h12BB_56DD;
  localparam subsys_pkg::xlen_t OE_FINAL   = 32'hFF00_FFFF;

  typedef struct packed {
    logic               rd;
    subsys_pkg::addr_t  addr;
    subsys_pkg::xlen_t  wdata;
    subsys_pkg::wmask_t mask;
    subsys_pkg::gpio_t  gin;
    subsys_pkg::xlen_t  exp_rdata;
    logic               exp_err;
  } row_t;

  logic               clk = 1'b0;
  logic               rst;
  logic               cmd_valid;
  logic               cmd_ready;
  subsys_pkg::addr_t  cmd_addr;
  logic               cmd_read;
  subsys_pkg::xlen_t  cmd_wdata;
  subsys_pkg::wmask_t cmd_wmask;
  logic               rsp_valid;
  logic               rsp_ready;
  logic               rsp_err;
  subsys_pkg::xlen_t  rsp_rdata;
  subsys_pkg::gpio_t  gpio_in;
  subsys_pkg::gpio_t  gpio_oval;
  subsys_pkg::gpio_t  gpio_oe;
  logic               inspect_mode;

  integer             seed;
  subsys_pkg::xlen_t  rdata;
  subsys_pkg::xlen_t  op_a;
  subsys_pkg::xlen_t  op_b;
  subsys_pkg::xlen_t  exp_sum;
  subsys_pkg::gpio_t  exp_pads;
  subsys_pkg::addr_t  ins_addr;
  logic               ins_rdy;
  logic               err;

  string row_name [NROWS] = '{
    "oval write", "oval read", "oval byte write", "oval byte read",
    "oe write", "oe byte write", "oe read", "gpio_in read", "gpio_in write",
    "gpio_in reread", "unmapped read", "unmapped write", "read after error"
  };

  // rd, addr, wdata, mask, gpio_in, expected rdata, expected err
  row_t rows [NROWS] = '{
    '{1'b0, OVAL_ADDR,    32'h1234_5678, 4'hf, 32'h0,         32'h0,         1'b0},
    '{1'b1, OVAL_ADDR,    32'h0,         4'h0, 32'h0,         32'h1234_5678, 1'b0},
    '{1'b0, OVAL_ADDR,    32'hAABB_CCDD, 4'h5, 32'h0,         32'h0,         1'b0},
    '{1'b1, OVAL_ADDR,    32'h0,         4'h0, 32'h0,         OVAL_FINAL,    1'b0},
    '{1'b0, OE_ADDR,      32'h0000_FFFF, 4'hf, 32'h0,         32'h0,         1'b0},
    '{1'b0, OE_ADDR,      32'hFFFF_0000, 4'h8, 32'h0,         32'h0,         1'b0},
    '{1'b1, OE_ADDR,      32'h0,         4'h0, 32'h0,         OE_FINAL,      1'b0},
    '{1'b1, GPIO_IN_ADDR, 32'h0,         4'h0, 32'hC0DE_5A17, 32'hC0DE_5A17, 1'b0},
    '{1'b0, GPIO_IN_ADDR, 32'hFFFF_FFFF, 4'hf, 32'hC0DE_5A17, 32'h0,         1'b0},
    '{1'b1, GPIO_IN_ADDR, 32'h0,         4'h0, 32'h0F0F_1234, 32'h0F0F_1234, 1'b0},
    '{1'b1, 32'h2000_0000, 32'h0,        4'h0, 32'h0,         32'h0,         1'b1},
    '{1'b0, 32'h1001_3004, 32'h5A5A_5A5A, 4'hf, 32'h0,        32'h0,         1'b1},
    '{1'b1, OVAL_ADDR,    32'h0,         4'h0, 32'h0,         OVAL_FINAL,    1'b0}
  };

  subsys_main uut (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_addr     (cmd_addr),
    .cmd_read     (cmd_read),
    .cmd_wdata    (cmd_wdata),
    .cmd_wmask    (cmd_wmask),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_err      (rsp_err),
    .rsp_rdata    (rsp_rdata),
    .gpio_in      (gpio_in),
    .gpio_oval    (gpio_oval),
    .gpio_oe      (gpio_oe),
    .inspect_mode (inspect_mode)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Helpers
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Starts and ends on a falling edge
  task automatic transfer(input string name, input logic rd, input subsys_pkg::addr_t addr,
                          input subsys_pkg::xlen_t wdata, input subsys_pkg::wmask_t mask,
                          output subsys_pkg::xlen_t data, output logic rsp_e);
    int          waited;
    int          hold;
    logic [31:0] rnd;
    rnd    = $random(seed);
    hold   = int'(rnd[1:0]);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run({"cmd_ready never went high in ", name});
    end while (!cmd_ready);
    cmd_valid = 1'b1;
    cmd_read  = rd;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    cmd_wmask = mask;
    rsp_ready = (hold == 0);
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run({"rsp_valid never arrived in ", name});
    end while (!rsp_valid);
    check({name, " rsp latency"}, 32'd1, 32'(waited));
    check({name, " cmd_ready while pending"}, 32'd0, 32'(cmd_ready));
    data  = rsp_rdata;
    rsp_e = rsp_err;
    // Response must hold while rsp_ready is low
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check({name, " held rsp_valid"}, 32'd1, 32'(rsp_valid));
      check({name, " held rsp_rdata"}, data, rsp_rdata);
      check({name, " held rsp_err"}, 32'(rsp_e), 32'(rsp_err));
      check({name, " cmd_ready under back-pressure"}, 32'd0, 32'(cmd_ready));
    end
    cmd_valid = 1'b0;
    rsp_ready = 1'b1;
    @(negedge clk);
    check({name, " rsp_valid after take"}, 32'd0, 32'(rsp_valid));
  endtask

  task automatic bus_write(input string name, input subsys_pkg::addr_t addr,
                           input subsys_pkg::xlen_t wdata);
    subsys_pkg::xlen_t data;
    logic              rsp_e;
    transfer(name, 1'b0, addr, wdata, 4'hf, data, rsp_e);
    check({name, " err"}, 32'd0, 32'(rsp_e));
    check({name, " rdata"}, 32'd0, data);
  endtask

  task automatic bus_read(input string name, input subsys_pkg::addr_t addr,
                          output subsys_pkg::xlen_t data);
    logic rsp_e;
    transfer(name, 1'b1, addr, 32'h0, 4'h0, data, rsp_e);
    check({name, " err"}, 32'd0, 32'(rsp_e));
  endtask

  ////////////////////
  // Sequence
  initial begin
    seed         = 32'h284bb541;
    rst          = 1'b1;
    cmd_valid    = 1'b0;
    cmd_addr     = subsys_pkg::GPIO_BASE;
    cmd_read     = 1'b0;
    cmd_wdata    = '0;
    cmd_wmask    = '0;
    rsp_ready    = 1'b1;
    gpio_in      = '0;
    inspect_mode = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("reset rsp_valid", 32'd0, 32'(rsp_valid));
    check("reset cmd_ready", 32'd1, 32'(cmd_ready));
    check("reset gpio_oe", 32'd0, gpio_oe);
    check("reset gpio_oval", 32'd0, gpio_oval);

    for (int i = 0; i < NROWS; i++) begin
      gpio_in = rows[i].gin;
      transfer(row_name[i], rows[i].rd, rows[i].addr, rows[i].wdata, rows[i].mask, rdata, err);
      check({row_name[i], " rdata"}, rows[i].exp_rdata, rdata);
      check({row_name[i], " err"}, 32'(rows[i].exp_err), 32'(err));
    end
    check("pads oval", OVAL_FINAL, gpio_oval);
    check("pads oe", OE_FINAL, gpio_oe);

    // Adder with random operands, sum is read-only
    for (int k = 0; k < 3; k++) begin
      op_a    = $random(seed);
      op_b    = $random(seed);
      exp_sum = op_a + op_b;
      bus_write("adder op_a", OP_A_ADDR, op_a);
      bus_write("adder op_b", OP_B_ADDR, op_b);
      bus_read("adder op_a read", OP_A_ADDR, rdata);
      check("adder op_a value", op_a, rdata);
      bus_read("adder sum", SUM_ADDR, rdata);
      check("adder sum value", exp_sum, rdata);
      bus_write("adder sum write", SUM_ADDR, ~exp_sum);
      bus_read("adder sum kept", SUM_ADDR, rdata);
      check("adder sum kept value", exp_sum, rdata);
    end

    ////////////////////
    // Inspect mode, bus idle
    for (int k = 0; k < 2; k++) begin
      ins_addr     = (k == 0) ? 32'h1234_5ABC : 32'hFFFF_FFFF;
      ins_rdy      = (k == 1);
      inspect_mode = 1'b1;
      cmd_valid    = 1'b0;
      cmd_addr     = ins_addr;
      rsp_ready    = ins_rdy;
      @(negedge clk);
      // Bits 25..22 are rsp_ready, rsp_valid, cmd_ready, cmd_valid
      exp_pads = {6'b0, ins_rdy, 1'b0, 1'b1, 1'b0, ins_addr[21:0]};
      check("inspect gpio_oe", 32'hFFFF_FFFF, gpio_oe);
      check("inspect gpio_oval", exp_pads, gpio_oval);
      inspect_mode = 1'b0;
      rsp_ready    = 1'b1;
      @(negedge clk);
      check("restored gpio_oval", OVAL_FINAL, gpio_oval);
      check("restored gpio_oe", OE_FINAL, gpio_oe);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule
